//--- src/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// bundle shape
`define WB_SLOTS        4
`define WB_GPR_ENTRIES  8
`define WB_SEG_ENTRIES  8

// datapath widths
`define WB_DATA_W       64
`define WB_SEG_W        16
`define WB_ADDR_W       32

`define WB_SQ_DEPTH     4   // pending stores

`endif

//--- src/wb_data_pkg.sv
`default_nettype none

`include "wb_config.svh"

package wb_data_pkg;

    // result word from execute
    typedef logic [`WB_DATA_W-1:0] data_t;

    // register index in low bits, or a memory address
    typedef logic [`WB_ADDR_W-1:0] dest_t;

    typedef logic [$clog2(`WB_GPR_ENTRIES)-1:0] reg_idx_t;

    typedef logic [`WB_SEG_W-1:0] seg_t;

    typedef enum logic [1:0] {
        SZ_8  = 2'd0,   // low byte
        SZ_16 = 2'd1,   // low 2 bytes
        SZ_32 = 2'd2,   // low 4 bytes
        SZ_64 = 2'd3    // full word
    } opsize_e;

endpackage

`default_nettype wire

//--- src/wb_ctrl_pkg.sv
`default_nettype none

`include "wb_config.svh"

package wb_ctrl_pkg;

    typedef logic [`WB_ADDR_W-1:0] eip_t;

    // bit 3 interrupt, bits 2:0 exception code
    typedef logic [3:0] ie_type_t;

    typedef enum logic [1:0] {
        SQ_EMPTY   = 2'd0,
        SQ_PARTIAL = 2'd1,
        SQ_FULL    = 2'd2
    } sq_state_e;

endpackage

`default_nettype wire

//--- src/arch_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module arch_reg_file #(
    parameter int ENTRIES = 8,
    parameter int WIDTH   = 64
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic [`WB_SLOTS-1:0]    ld,
    input  wire wb_data_pkg::reg_idx_t   idx1,
    input  wire wb_data_pkg::reg_idx_t   idx2,
    input  wire wb_data_pkg::reg_idx_t   idx3,
    input  wire wb_data_pkg::reg_idx_t   idx4,
    input  wire logic [WIDTH-1:0]        wdata1,
    input  wire logic [WIDTH-1:0]        wdata2,
    input  wire logic [WIDTH-1:0]        wdata3,
    input  wire logic [WIDTH-1:0]        wdata4,
    input  wire wb_data_pkg::opsize_e    size,
    input  wire logic                    size_mask_en,
    input  wire wb_data_pkg::reg_idx_t   rd_addr,
    output logic [WIDTH-1:0]             rd_data
);

    logic [WIDTH-1:0]        regs  [ENTRIES];
    logic [WIDTH-1:0]        wdata [`WB_SLOTS];
    wb_data_pkg::reg_idx_t   idx   [`WB_SLOTS];
    logic [`WB_DATA_W-1:0]   mask;

    assign wdata = '{wdata1, wdata2, wdata3, wdata4};
    assign idx   = '{idx1, idx2, idx3, idx4};

    always_comb begin
        case (size)
            wb_data_pkg::SZ_8:  mask = `WB_DATA_W'(8'hff);
            wb_data_pkg::SZ_16: mask = `WB_DATA_W'(16'hffff);
            wb_data_pkg::SZ_32: mask = `WB_DATA_W'(32'hffff_ffff);
            default:            mask = '1;
        endcase
        if (!size_mask_en) begin
            mask = '1;      // segment file takes the whole value
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // later port overrides, so slot 4 wins
            for (int p = 0; p < `WB_SLOTS; p++) begin
                if (ld[p]) begin
                    regs[idx[p]] <= (regs[idx[p]] & ~mask[WIDTH-1:0]) |
                                    (wdata[p] & mask[WIDTH-1:0]);
                end
            end
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

//--- src/store_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module store_queue (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   push,
    input  wire wb_data_pkg::dest_t     addr,
    input  wire wb_data_pkg::data_t     data,
    input  wire wb_data_pkg::opsize_e   size,
    input  wire logic                   mem_wr_ready,
    output logic                        full,
    output logic                        mem_wr_valid,
    output wb_data_pkg::dest_t          mem_wr_addr,
    output wb_data_pkg::data_t          mem_wr_data,
    output wb_data_pkg::opsize_e        mem_wr_size
);

    localparam int PTR_W = $clog2(`WB_SQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    wb_data_pkg::dest_t      addr_q [`WB_SQ_DEPTH];
    wb_data_pkg::data_t      data_q [`WB_SQ_DEPTH];
    wb_data_pkg::opsize_e    size_q [`WB_SQ_DEPTH];

    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;
    logic [CNT_W-1:0]        count_nxt;
    wb_ctrl_pkg::sq_state_e  sq_state;
    wb_ctrl_pkg::sq_state_e  sq_state_nxt;
    logic                    do_push;
    logic                    do_pop;

    assign full         = (sq_state == wb_ctrl_pkg::SQ_FULL);
    assign mem_wr_valid = (sq_state != wb_ctrl_pkg::SQ_EMPTY);
    assign do_push      = push & ~full;     // stage stalls before this drops anything
    assign do_pop       = mem_wr_valid & mem_wr_ready;

    // head entry straight off the storage flops
    assign mem_wr_addr = addr_q[rd_ptr];
    assign mem_wr_data = data_q[rd_ptr];
    assign mem_wr_size = size_q[rd_ptr];

    always_comb begin
        count_nxt = count + CNT_W'(do_push) - CNT_W'(do_pop);
        if (count_nxt == '0) begin
            sq_state_nxt = wb_ctrl_pkg::SQ_EMPTY;
        end else if (count_nxt == CNT_W'(`WB_SQ_DEPTH)) begin
            sq_state_nxt = wb_ctrl_pkg::SQ_FULL;
        end else begin
            sq_state_nxt = wb_ctrl_pkg::SQ_PARTIAL;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            sq_state <= wb_ctrl_pkg::SQ_EMPTY;
        end else begin
            count    <= count_nxt;
            sq_state <= sq_state_nxt;
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`WB_SQ_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`WB_SQ_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_q[wr_ptr] <= addr;
            data_q[wr_ptr] <= data;
            size_q[wr_ptr] <= size;
        end
    end

endmodule

`default_nettype wire

//--- src/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module writeback_stage (
    input  wire logic                     valid_in,
    input  wire wb_data_pkg::data_t       slot1_data,
    input  wire wb_data_pkg::data_t       slot2_data,
    input  wire wb_data_pkg::data_t       slot3_data,
    input  wire wb_data_pkg::data_t       slot4_data,
    input  wire wb_data_pkg::dest_t       slot1_dest,
    input  wire wb_data_pkg::dest_t       slot2_dest,
    input  wire wb_data_pkg::dest_t       slot3_dest,
    input  wire wb_data_pkg::dest_t       slot4_dest,
    input  wire logic                     slot1_is_reg,
    input  wire logic                     slot2_is_reg,
    input  wire logic                     slot3_is_reg,
    input  wire logic                     slot4_is_reg,
    input  wire logic                     slot1_is_seg,
    input  wire logic                     slot2_is_seg,
    input  wire logic                     slot3_is_seg,
    input  wire logic                     slot4_is_seg,
    input  wire logic                     slot1_is_mem,
    input  wire logic                     slot2_is_mem,
    input  wire logic                     slot3_is_mem,
    input  wire logic                     slot4_is_mem,
    input  wire logic                     slot1_wb,
    input  wire logic                     slot2_wb,
    input  wire logic                     slot3_wb,
    input  wire logic                     slot4_wb,
    input  wire wb_data_pkg::opsize_e     size,
    input  wire logic                     far_xfer,
    input  wire wb_ctrl_pkg::eip_t        eip_in,
    input  wire logic                     br_valid_in,
    input  wire logic                     br_taken_in,
    input  wire logic                     br_correct_in,
    input  wire wb_ctrl_pkg::eip_t        br_fip_in,
    input  wire wb_ctrl_pkg::eip_t        br_fip_p1_in,
    input  wire logic                     ie_in,
    input  wire wb_ctrl_pkg::ie_type_t    ie_type_in,
    input  wire logic                     interrupt_in,
    input  wire logic                     sq_full,
    output logic                          valid_out,
    output logic                          stall,
    output logic [`WB_SLOTS-1:0]          reg_ld,
    output logic [`WB_SLOTS-1:0]          seg_ld,
    output wb_data_pkg::reg_idx_t         reg_idx1,
    output wb_data_pkg::reg_idx_t         reg_idx2,
    output wb_data_pkg::reg_idx_t         reg_idx3,
    output wb_data_pkg::reg_idx_t         reg_idx4,
    output wb_data_pkg::data_t            res1,
    output wb_data_pkg::data_t            res2,
    output wb_data_pkg::data_t            res3,
    output wb_data_pkg::data_t            res4,
    output logic                          sq_push,
    output wb_data_pkg::dest_t            sq_addr,
    output wb_data_pkg::data_t            sq_data,
    output wb_data_pkg::opsize_e          sq_size,
    output wb_ctrl_pkg::eip_t             new_eip,
    output wb_ctrl_pkg::eip_t             new_fip_e,
    output wb_ctrl_pkg::eip_t             new_fip_o,
    output logic                          is_resteer,
    output logic                          br_valid,
    output logic                          br_taken,
    output logic                          br_correct,
    output wb_data_pkg::seg_t             cs_out,
    output logic                          final_ie_val,
    output wb_ctrl_pkg::ie_type_t         final_ie_type
);

    logic                 has_store;
    wb_data_pkg::seg_t    far_sel;
    wb_ctrl_pkg::eip_t    fip_lo;
    wb_ctrl_pkg::eip_t    fip_hi;
    wb_ctrl_pkg::eip_t    target_eip;

    // stall must not depend on valid_out
    assign has_store = slot1_is_mem | slot2_is_mem | slot3_is_mem | slot4_is_mem;
    assign stall     = valid_in & has_store & sq_full;
    assign valid_out = valid_in & ~stall;

    assign reg_ld = {slot4_is_reg & slot4_wb, slot3_is_reg & slot3_wb,
                     slot2_is_reg & slot2_wb, slot1_is_reg & slot1_wb} & {`WB_SLOTS{valid_out}};
    assign seg_ld = {slot4_is_seg & slot4_wb, slot3_is_seg & slot3_wb,
                     slot2_is_seg & slot2_wb, slot1_is_seg & slot1_wb} & {`WB_SLOTS{valid_out}};

    assign reg_idx1 = slot1_dest[2:0];
    assign reg_idx2 = slot2_dest[2:0];
    assign reg_idx3 = slot3_dest[2:0];
    assign reg_idx4 = slot4_dest[2:0];

    // far pointer selector sits in bits 47:32 of slot 1
    assign far_sel = slot1_data[47:32];
    assign res1    = far_xfer ? {48'd0, far_sel} : slot1_data;
    assign res2    = slot2_data;
    assign res3    = slot3_data;
    assign res4    = slot4_data;
    assign cs_out  = far_xfer ? far_sel : '0;

    // lowest memory slot wins
    always_comb begin
        if (slot1_is_mem) begin
            sq_addr = slot1_dest;
            sq_data = res1;
        end else if (slot2_is_mem) begin
            sq_addr = slot2_dest;
            sq_data = res2;
        end else if (slot3_is_mem) begin
            sq_addr = slot3_dest;
            sq_data = res3;
        end else begin
            sq_addr = slot4_dest;
            sq_data = res4;
        end
    end

    assign sq_push = has_store & valid_out;
    assign sq_size = far_xfer ? wb_data_pkg::SZ_16 : size;

    assign target_eip = far_xfer ? slot1_data[31:0] : br_fip_in;
    assign new_eip    = br_taken_in ? target_eip : eip_in;

    // bit 4 decides which 16-byte line is even
    assign fip_lo    = {br_fip_in[31:4], 4'h0};
    assign fip_hi    = {br_fip_p1_in[31:4], 4'h0};
    assign new_fip_e = br_fip_in[4] ? fip_hi : fip_lo;
    assign new_fip_o = br_fip_in[4] ? fip_lo : fip_hi;

    assign is_resteer = br_valid_in & ~br_correct_in;
    assign br_valid   = br_valid_in;
    assign br_taken   = br_taken_in;
    assign br_correct = br_correct_in;

    assign final_ie_val  = ie_in | interrupt_in;
    assign final_ie_type = {interrupt_in, ie_type_in[2:0]};

endmodule

`default_nettype wire

//--- src/writeback_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module writeback_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    valid_in,
    input  wire wb_data_pkg::data_t      slot1_data,
    input  wire wb_data_pkg::data_t      slot2_data,
    input  wire wb_data_pkg::data_t      slot3_data,
    input  wire wb_data_pkg::data_t      slot4_data,
    input  wire wb_data_pkg::dest_t      slot1_dest,
    input  wire wb_data_pkg::dest_t      slot2_dest,
    input  wire wb_data_pkg::dest_t      slot3_dest,
    input  wire wb_data_pkg::dest_t      slot4_dest,
    input  wire logic                    slot1_is_reg,
    input  wire logic                    slot2_is_reg,
    input  wire logic                    slot3_is_reg,
    input  wire logic                    slot4_is_reg,
    input  wire logic                    slot1_is_seg,
    input  wire logic                    slot2_is_seg,
    input  wire logic                    slot3_is_seg,
    input  wire logic                    slot4_is_seg,
    input  wire logic                    slot1_is_mem,
    input  wire logic                    slot2_is_mem,
    input  wire logic                    slot3_is_mem,
    input  wire logic                    slot4_is_mem,
    input  wire logic                    slot1_wb,
    input  wire logic                    slot2_wb,
    input  wire logic                    slot3_wb,
    input  wire logic                    slot4_wb,
    input  wire wb_data_pkg::opsize_e    size,
    input  wire logic                    far_xfer,
    input  wire wb_ctrl_pkg::eip_t       eip_in,
    input  wire logic                    br_valid_in,
    input  wire logic                    br_taken_in,
    input  wire logic                    br_correct_in,
    input  wire wb_ctrl_pkg::eip_t       br_fip_in,
    input  wire wb_ctrl_pkg::eip_t       br_fip_p1_in,
    input  wire logic                    ie_in,
    input  wire wb_ctrl_pkg::ie_type_t   ie_type_in,
    input  wire logic                    interrupt_in,
    input  wire logic                    mem_wr_ready,
    input  wire wb_data_pkg::reg_idx_t   gpr_rd_addr,
    input  wire wb_data_pkg::reg_idx_t   seg_rd_addr,
    output logic                         valid_out,
    output logic                         stall,
    output wb_ctrl_pkg::eip_t            new_eip,
    output wb_ctrl_pkg::eip_t            new_fip_e,
    output wb_ctrl_pkg::eip_t            new_fip_o,
    output logic                         is_resteer,
    output logic                         br_valid,
    output logic                         br_taken,
    output logic                         br_correct,
    output wb_data_pkg::seg_t            cs_out,
    output logic                         final_ie_val,
    output wb_ctrl_pkg::ie_type_t        final_ie_type,
    output logic                         mem_wr_valid,
    output wb_data_pkg::dest_t           mem_wr_addr,
    output wb_data_pkg::data_t           mem_wr_data,
    output wb_data_pkg::opsize_e         mem_wr_size,
    output wb_data_pkg::data_t           gpr_rd_data,
    output wb_data_pkg::seg_t            seg_rd_data
);

    logic [`WB_SLOTS-1:0]    reg_ld;
    logic [`WB_SLOTS-1:0]    seg_ld;
    wb_data_pkg::reg_idx_t   reg_idx1, reg_idx2, reg_idx3, reg_idx4;
    wb_data_pkg::data_t      res1, res2, res3, res4;
    logic                    sq_push;
    logic                    sq_full;
    wb_data_pkg::dest_t      sq_addr;
    wb_data_pkg::data_t      sq_data;
    wb_data_pkg::opsize_e    sq_size;

    writeback_stage u_stage (.*);

    arch_reg_file #(.ENTRIES(`WB_GPR_ENTRIES), .WIDTH(`WB_DATA_W)) u_gpr (
        .clk, .rst_n, .ld(reg_ld),
        .idx1(reg_idx1), .idx2(reg_idx2), .idx3(reg_idx3), .idx4(reg_idx4),
        .wdata1(res1), .wdata2(res2), .wdata3(res3), .wdata4(res4),
        .size, .size_mask_en(1'b1), .rd_addr(gpr_rd_addr), .rd_data(gpr_rd_data)
    );

    // segment file takes the low 16 bits of each result
    arch_reg_file #(.ENTRIES(`WB_SEG_ENTRIES), .WIDTH(`WB_SEG_W)) u_seg (
        .clk, .rst_n, .ld(seg_ld),
        .idx1(reg_idx1), .idx2(reg_idx2), .idx3(reg_idx3), .idx4(reg_idx4),
        .wdata1(res1[`WB_SEG_W-1:0]), .wdata2(res2[`WB_SEG_W-1:0]),
        .wdata3(res3[`WB_SEG_W-1:0]), .wdata4(res4[`WB_SEG_W-1:0]),
        .size, .size_mask_en(1'b0), .rd_addr(seg_rd_addr), .rd_data(seg_rd_data)
    );

    store_queue u_sq (
        .clk, .rst_n, .push(sq_push), .addr(sq_addr), .data(sq_data), .size(sq_size),
        .mem_wr_ready, .full(sq_full), .mem_wr_valid, .mem_wr_addr, .mem_wr_data,
        .mem_wr_size
    );

endmodule

`default_nettype wire

//--- test/tb_writeback_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module tb_writeback_top;

    localparam int MAX_WAIT = 200;

    logic                    clk;
    logic                    rst_n;
    logic                    valid_in;
    wb_data_pkg::data_t      s_data [4];
    wb_data_pkg::dest_t      s_dest [4];
    logic [3:0]              s_reg;
    logic [3:0]              s_seg;
    logic [3:0]              s_mem;
    logic [3:0]              s_wb;
    wb_data_pkg::opsize_e    size;
    logic                    far_xfer;
    wb_ctrl_pkg::eip_t       eip_in;
    wb_ctrl_pkg::eip_t       br_fip_in;
    wb_ctrl_pkg::eip_t       br_fip_p1_in;
    logic                    br_valid_in;
    logic                    br_taken_in;
    logic                    br_correct_in;
    logic                    ie_in;
    wb_ctrl_pkg::ie_type_t   ie_type_in;
    logic                    interrupt_in;
    logic                    mem_wr_ready;
    wb_data_pkg::reg_idx_t   gpr_rd_addr;
    wb_data_pkg::reg_idx_t   seg_rd_addr;

    logic                    valid_out;
    logic                    stall;
    wb_ctrl_pkg::eip_t       new_eip;
    wb_ctrl_pkg::eip_t       new_fip_e;
    wb_ctrl_pkg::eip_t       new_fip_o;
    logic                    is_resteer;
    logic                    br_valid;
    logic                    br_taken;
    logic                    br_correct;
    wb_data_pkg::seg_t       cs_out;
    logic                    final_ie_val;
    wb_ctrl_pkg::ie_type_t   final_ie_type;
    logic                    mem_wr_valid;
    wb_data_pkg::dest_t      mem_wr_addr;
    wb_data_pkg::data_t      mem_wr_data;
    wb_data_pkg::opsize_e    mem_wr_size;
    wb_data_pkg::data_t      gpr_rd_data;
    wb_data_pkg::seg_t       seg_rd_data;

    // next bundle to present
    wb_data_pkg::data_t      t_data [4];
    wb_data_pkg::dest_t      t_dest [4];
    logic [3:0]              t_reg;
    logic [3:0]              t_seg;
    logic [3:0]              t_mem;
    logic [3:0]              t_wb;
    wb_data_pkg::opsize_e    t_size;
    logic                    t_far;

    // reference model
    wb_data_pkg::data_t      gpr_ref [`WB_GPR_ENTRIES];
    wb_data_pkg::seg_t       seg_ref [`WB_SEG_ENTRIES];
    wb_data_pkg::dest_t      exp_addr [$];
    wb_data_pkg::data_t      exp_data [$];
    wb_data_pkg::opsize_e    exp_size [$];

    int                      n_checks;
    int                      n_mismatch;
    int                      n_other;
    string                   test_name;
    logic [31:0]             rnd_state = 32'ha066;
    bit                      rand_ready = 1'b0;

    writeback_top u_dut (
        .*,
        .slot1_data(s_data[0]), .slot2_data(s_data[1]),
        .slot3_data(s_data[2]), .slot4_data(s_data[3]),
        .slot1_dest(s_dest[0]), .slot2_dest(s_dest[1]),
        .slot3_dest(s_dest[2]), .slot4_dest(s_dest[3]),
        .slot1_is_reg(s_reg[0]), .slot2_is_reg(s_reg[1]),
        .slot3_is_reg(s_reg[2]), .slot4_is_reg(s_reg[3]),
        .slot1_is_seg(s_seg[0]), .slot2_is_seg(s_seg[1]),
        .slot3_is_seg(s_seg[2]), .slot4_is_seg(s_seg[3]),
        .slot1_is_mem(s_mem[0]), .slot2_is_mem(s_mem[1]),
        .slot3_is_mem(s_mem[2]), .slot4_is_mem(s_mem[3]),
        .slot1_wb(s_wb[0]), .slot2_wb(s_wb[1]), .slot3_wb(s_wb[2]), .slot4_wb(s_wb[3])
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_rand();
        return r[3];
    endfunction

    // bytes written for each operand size
    function automatic wb_data_pkg::data_t size_mask(input wb_data_pkg::opsize_e sz);
        case (sz)
            wb_data_pkg::SZ_8:  return 64'hff;
            wb_data_pkg::SZ_16: return 64'hffff;
            wb_data_pkg::SZ_32: return 64'hffff_ffff;
            default:            return '1;
        endcase
    endfunction

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (exp !== act) begin
            n_mismatch++;
            $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic fail_other(input string msg);
        n_other++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic end_run();
        $display("checks: %0d, mismatches: %0d, other errors: %0d",
                 n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic tick();
        @(posedge clk);
        if (rand_ready) begin
            mem_wr_ready <= rand_bit();     // random back-pressure
        end
    endtask

    task automatic random_slots();
        logic [31:0] r;
        r = next_rand();
        for (int i = 0; i < 4; i++) begin
            t_data[i] = {next_rand(), next_rand()};
            t_dest[i] = next_rand();
        end
        t_reg = r[3:0];
        t_seg = r[7:4];
        t_mem = r[11:8];
        t_wb = r[15:12] | r[19:16];     // mostly set
        t_size = wb_data_pkg::opsize_e'(r[21:20]);
        t_far = (r[24:22] == 3'd0);
    endtask

    task automatic drive_bundle(input logic valid);
        tick();
        valid_in <= valid;
        for (int i = 0; i < 4; i++) begin
            s_data[i] <= t_data[i];
            s_dest[i] <= t_dest[i];
        end
        s_reg <= t_reg;
        s_seg <= t_seg;
        s_mem <= t_mem;
        s_wb <= t_wb;
        size <= t_size;
        far_xfer <= t_far;
    endtask

    task automatic update_model();
        wb_data_pkg::data_t res;
        wb_data_pkg::data_t m;
        bit stored;
        m = size_mask(t_size);
        stored = 1'b0;
        for (int i = 0; i < 4; i++) begin
            res = (i == 0 && t_far) ? {48'd0, t_data[0][47:32]} : t_data[i];
            if (t_reg[i] && t_wb[i]) begin
                gpr_ref[t_dest[i][2:0]] = (gpr_ref[t_dest[i][2:0]] & ~m) | (res & m);
            end
            if (t_seg[i] && t_wb[i]) begin
                seg_ref[t_dest[i][2:0]] = res[15:0];
            end
            if (t_mem[i] && !stored) begin
                stored = 1'b1;      // lowest memory slot only
                exp_addr.push_back(t_dest[i]);
                exp_data.push_back(res);
                exp_size.push_back(t_far ? wb_data_pkg::SZ_16 : t_size);
            end
        end
    endtask

    task automatic present_bundle(output bit acc);
        bit exp_full;
        drive_bundle(1'b1);
        exp_full = (exp_addr.size() == `WB_SQ_DEPTH);     // stores held in the queue now
        @(negedge clk);
        acc = !(exp_full && t_mem != 4'b0);
        check_eq("stall", 64'(!acc), 64'(stall));
        check_eq("valid_out", 64'(acc), 64'(valid_out));
        check_eq("cs_out", t_far ? 64'(t_data[0][47:32]) : 64'd0, 64'(cs_out));
        if (acc) begin
            update_model();
        end
    endtask

    task automatic idle();
        tick();
        valid_in <= 1'b0;
    endtask

    task automatic send_bundle();
        bit acc;
        int tries;
        tries = 0;
        present_bundle(acc);
        while (!acc) begin
            tries++;
            if (tries == MAX_WAIT) begin
                fail_other("bundle was never accepted before the timeout");
                end_run();
            end
            present_bundle(acc);
        end
        idle();
    endtask

    task automatic check_regs();
        for (int r = 0; r < `WB_GPR_ENTRIES; r++) begin
            tick();
            gpr_rd_addr <= r[2:0];
            seg_rd_addr <= r[2:0];
            @(negedge clk);
            check_eq($sformatf("gpr[%0d]", r), gpr_ref[r], gpr_rd_data);
            check_eq($sformatf("seg[%0d]", r), 64'(seg_ref[r]), 64'(seg_rd_data));
        end
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (exp_addr.size() != 0 || mem_wr_valid) begin
            cnt++;
            if (cnt == MAX_WAIT) begin
                fail_other("store queue did not drain before the timeout");
                end_run();
            end
            tick();
            @(negedge clk);
        end
    endtask

    // transfer lands on the next rising edge
    always @(negedge clk) begin
        if (rst_n && mem_wr_valid && mem_wr_ready) begin
            if (exp_addr.size() == 0) begin
                fail_other("a store showed up on the memory port with none expected");
            end else begin
                check_eq("mem_wr_addr", 64'(exp_addr.pop_front()), 64'(mem_wr_addr));
                check_eq("mem_wr_data", exp_data.pop_front(), mem_wr_data);
                check_eq("mem_wr_size", 64'(exp_size.pop_front()), 64'(mem_wr_size));
            end
        end
    end

    task automatic test_reg_writeback();
        logic [31:0] r;
        test_name = "reg_writeback";
        for (int n = 0; n < 40; n++) begin
            r = next_rand();
            random_slots();
            t_seg = '0;
            t_mem = '0;
            t_far = 1'b0;
            if (n % 4 == 0) begin
                t_dest[1] = t_dest[0];      // slot 4 must win the shared index
                t_dest[2] = t_dest[0];
                t_dest[3] = t_dest[0];
            end
            if (r[2:0] == 3'd0) begin
                drive_bundle(1'b0);
                @(negedge clk);
                check_eq("valid_out, invalid bundle", 64'd0, 64'(valid_out));
                check_eq("stall, invalid bundle", 64'd0, 64'(stall));
            end else begin
                send_bundle();
            end
            check_regs();
        end
    endtask

    task automatic test_seg_writeback();
        test_name = "seg_writeback";
        for (int n = 0; n < 12; n++) begin
            random_slots();
            t_mem = '0;
            t_far = (n % 4 == 3);
            if (t_far) begin
                t_seg[0] = 1'b1;
                t_wb[0] = 1'b1;
            end
            send_bundle();
            check_regs();
        end
    endtask

    task automatic test_store_order();
        test_name = "store_order";
        rand_ready = 1'b1;
        for (int n = 0; n < 30; n++) begin
            random_slots();
            if (t_mem == 4'b0) begin
                t_mem[n % 4] = 1'b1;
            end
            send_bundle();
        end
        drain();
        rand_ready = 1'b0;
        tick();
        mem_wr_ready <= 1'b1;
        check_regs();
    endtask

    task automatic test_full_stall();
        bit acc;
        test_name = "full_stall";
        tick();
        mem_wr_ready <= 1'b0;
        for (int n = 0; n < `WB_SQ_DEPTH; n++) begin
            random_slots();
            t_mem = 4'b0010;
            present_bundle(acc);
            idle();
        end
        random_slots();
        t_mem = 4'b0001;
        present_bundle(acc);
        check_eq("stall, queue full", 64'd1, 64'(stall));
        check_eq("valid_out, queue full", 64'd0, 64'(valid_out));
        random_slots();
        t_mem = 4'b0;
        t_wb = 4'hf;
        present_bundle(acc);
        check_eq("stall, register bundle", 64'd0, 64'(stall));
        check_eq("valid_out, register bundle", 64'd1, 64'(valid_out));
        idle();
        check_regs();
        random_slots();
        t_mem = 4'b0100;
        tick();
        mem_wr_ready <= 1'b1;       // frees an entry
        send_bundle();
        drain();
    endtask

    task automatic test_branch();
        logic [31:0] fip;
        logic [31:0] fip_p1;
        logic [31:0] eip;
        logic [63:0] d0;
        logic [31:0] lo;
        logic [31:0] hi;
        test_name = "branch";
        for (int c = 0; c < 32; c++) begin
            fip = next_rand();
            fip[4] = c[4];
            fip_p1 = next_rand();
            eip = next_rand();
            d0 = {next_rand(), next_rand()};
            tick();
            br_valid_in <= c[0];
            br_taken_in <= c[1];
            far_xfer <= c[2];
            br_correct_in <= c[3];
            br_fip_in <= fip;
            br_fip_p1_in <= fip_p1;
            eip_in <= eip;
            s_data[0] <= d0;
            @(negedge clk);
            lo = {fip[31:4], 4'h0};
            hi = {fip_p1[31:4], 4'h0};
            check_eq("new_eip", 64'(c[1] ? (c[2] ? d0[31:0] : fip) : eip), 64'(new_eip));
            check_eq("new_fip_e", 64'(fip[4] ? hi : lo), 64'(new_fip_e));
            check_eq("new_fip_o", 64'(fip[4] ? lo : hi), 64'(new_fip_o));
            check_eq("is_resteer", 64'(c[0] & ~c[3]), 64'(is_resteer));
            check_eq("br_valid", 64'(c[0]), 64'(br_valid));
            check_eq("br_taken", 64'(c[1]), 64'(br_taken));
            check_eq("br_correct", 64'(c[3]), 64'(br_correct));
        end
        tick();
        far_xfer <= 1'b0;
    endtask

    task automatic test_exception();
        logic [31:0] r;
        test_name = "exception";
        for (int c = 0; c < 8; c++) begin
            r = next_rand();
            tick();
            ie_in <= c[0];
            interrupt_in <= c[1];
            ie_type_in <= r[3:0];
            @(negedge clk);
            check_eq("final_ie_val", 64'(c[0] | c[1]), 64'(final_ie_val));
            check_eq("final_ie_type", 64'({c[1], r[2:0]}), 64'(final_ie_type));
        end
    endtask

    initial begin
        rst_n = 1'b0;
        valid_in = 1'b0;
        for (int i = 0; i < 4; i++) begin
            s_data[i] = '0;
            s_dest[i] = '0;
            t_data[i] = '0;
            t_dest[i] = '0;
        end
        s_reg = '0;
        s_seg = '0;
        s_mem = '0;
        s_wb = '0;
        size = wb_data_pkg::SZ_64;
        far_xfer = 1'b0;
        eip_in = '0;
        br_fip_in = '0;
        br_fip_p1_in = '0;
        br_valid_in = 1'b0;
        br_taken_in = 1'b0;
        br_correct_in = 1'b0;
        ie_in = 1'b0;
        ie_type_in = '0;
        interrupt_in = 1'b0;
        mem_wr_ready = 1'b1;
        gpr_rd_addr = '0;
        seg_rd_addr = '0;
        for (int r = 0; r < `WB_GPR_ENTRIES; r++) begin
            gpr_ref[r] = '0;
            seg_ref[r] = '0;
        end
        n_checks = 0;
        n_mismatch = 0;
        n_other = 0;
        test_name = "reset";
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reg_writeback();
        test_seg_writeback();
        test_store_order();
        test_full_stall();
        test_branch();
        test_exception();
        if (exp_addr.size() != 0) begin
            fail_other("expected stores never reached the memory port");
        end
        end_run();
    end

endmodule

`default_nettype wire

//--- writeback_top.f
+incdir+src
src/wb_data_pkg.sv
src/wb_ctrl_pkg.sv
src/arch_reg_file.sv
src/store_queue.sv
src/writeback_stage.sv
src/writeback_top.sv
test/tb_writeback_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timescale 1ns/1ps --top-module tb_writeback_top \
    -f writeback_top.f -o tb_writeback_top > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_writeback_top > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
